// ==== cram_cfg.svh ====
`ifndef CRAM_CFG_SVH
`define CRAM_CFG_SVH

// bus widths
`define CRAM_AW 16
`define CRAM_DW 16

// host address that maps onto the memory's configuration register
`define CRAM_CTRL_ADDR 16'hFFFA

// wait cycles after the address cycle
`define CRAM_LAT_DEFAULT 3
`define CRAM_LAT_MIN 2
`define CRAM_LAT_MAX 6

// words per burst read
`define CRAM_BURST_LEN 4

`endif

// ==== busPkg.sv ====
`default_nettype none

`include "cram_cfg.svh"

package busPkg;

    typedef enum logic [1:0] {
        accWrite,
        accRead,
        accBurstRead
    } accessKind;

    // host request, valid is a one-cycle strobe
    typedef struct packed {
        logic                valid;
        accessKind           kind;
        logic [`CRAM_AW-1:0] addr;
        logic [`CRAM_DW-1:0] wdata;
    } busReq;

    // word k of the line sits at line[k*DW +: DW]
    typedef struct packed {
        logic                                valid;
        logic                                single; // only word 0 meaningful
        logic [`CRAM_BURST_LEN*`CRAM_DW-1:0] line;
    } busRsp;

endpackage

`default_nettype wire

// ==== cramPkg.sv ====
`default_nettype none

`include "cram_cfg.svh"

package cramPkg;

    typedef enum logic [1:0] {
        opRead,
        opWrite,
        opCfgWrite,
        opCfgRead
    } cramCmdOp;

    typedef struct packed {
        logic                start;  // one-cycle strobe
        cramCmdOp            op;
        logic [`CRAM_AW-1:0] addr;
        logic [`CRAM_DW-1:0] wdata;
        logic [2:0]          beats;  // 1 or 4
    } cramCmd;

    // memory side pins, data bus split instead of inout
    typedef struct packed {
        logic [`CRAM_AW-1:0] maddr;
        logic [`CRAM_DW-1:0] mdataOut;
        logic                mdataOe;
        logic                moeN;
        logic                mweN;
        logic                madvN;
        logic                mceN;
        logic                mcre;
        logic                mclkEn; // qualifies clk50MHz as the memory clock
        logic                mubN;
        logic                mlbN;
    } cramPins;

    typedef enum logic [2:0] {
        stIdle,
        stAddr,
        stWait,
        stData,
        stCfg
    } cramState;

    typedef struct packed {
        logic [`CRAM_AW-5:0] reserved;
        logic [2:0]          latency;
        logic                burstWrap;
    } cramCfgFields;

    // config register word as seen on maddr during the CRE cycle
    typedef union packed {
        logic [`CRAM_AW-1:0] raw;
        cramCfgFields        fields;
    } cramCfgWord;

endpackage

`default_nettype wire

// ==== cramBusBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cram_cfg.svh"

module cramBusBridge (
    input  logic                clk50MHz,
    input  logic                rstN,
    input  busPkg::busReq       req,
    input  logic                wordValid,
    input  logic [`CRAM_DW-1:0] wordData,
    input  logic                done,
    input  logic [2:0]          latencyNow,
    output cramPkg::cramCmd     cmd,
    output busPkg::busRsp       rsp,
    output logic                busy
);
    import busPkg::*;
    import cramPkg::*;

    localparam int LineW = `CRAM_BURST_LEN * `CRAM_DW;

    logic                accept;
    logic                isCtrl;
    logic                lastBeat;
    logic                waitRead;  // line fills from wordValid
    logic                waitWrite; // response follows done
    logic [2:0]          beatCnt;
    logic [2:0]          beatsReq;
    logic                rspValid;
    logic                rspSingle;
    logic [LineW-1:0]    lineReg;
    logic                cmdStart;
    cramCmdOp            cmdOp;
    logic [`CRAM_AW-1:0] cmdAddr;
    logic [`CRAM_DW-1:0] cmdWdata;
    logic [2:0]          cmdBeats;

    assign accept   = req.valid && !busy;
    assign isCtrl   = req.addr == `CRAM_CTRL_ADDR;
    assign lastBeat = (beatCnt + 3'd1) == beatsReq;

    always_ff @(posedge clk50MHz or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            cmdStart  <= 1'b0;
            rspValid  <= 1'b0;
            rspSingle <= 1'b0;
            waitRead  <= 1'b0;
            waitWrite <= 1'b0;
            beatCnt   <= '0;
            beatsReq  <= '0;
        end else begin
            cmdStart <= 1'b0;
            rspValid <= 1'b0;
            if (rspValid) begin
                busy <= 1'b0;
            end
            if (accept) begin
                busy    <= 1'b1;
                beatCnt <= '0;
                if (isCtrl && req.kind != accWrite) begin
                    // shadow latency answered locally, no memory cycle
                    rspValid  <= 1'b1;
                    rspSingle <= 1'b1;
                end else begin
                    cmdStart  <= 1'b1;
                    waitWrite <= req.kind == accWrite;
                    waitRead  <= req.kind != accWrite;
                    beatsReq  <= (req.kind == accBurstRead) ? 3'(`CRAM_BURST_LEN) : 3'd1;
                end
            end
            if (wordValid && waitRead) begin
                beatCnt <= beatCnt + 3'd1;
                if (lastBeat) begin
                    rspValid  <= 1'b1;
                    rspSingle <= beatsReq == 3'd1;
                    waitRead  <= 1'b0;
                end
            end
            if (done && waitWrite) begin
                rspValid  <= 1'b1;
                rspSingle <= 1'b1;
                waitWrite <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (accept) begin
            cmdAddr  <= req.addr;
            cmdWdata <= req.wdata;
            cmdBeats <= (req.kind == accBurstRead) ? 3'(`CRAM_BURST_LEN) : 3'd1;
            if (isCtrl) begin
                cmdOp   <= opCfgWrite;
                lineReg <= {{(LineW-3){1'b0}}, latencyNow};
            end else begin
                cmdOp <= (req.kind == accWrite) ? opWrite : opRead;
            end
        end
        if (wordValid) begin
            lineReg[beatCnt*`CRAM_DW +: `CRAM_DW] <= wordData;
        end
    end

    always_comb begin
        cmd.start  = cmdStart;
        cmd.op     = cmdOp;
        cmd.addr   = cmdAddr;
        cmd.wdata  = cmdWdata;
        cmd.beats  = cmdBeats;
        rsp.valid  = rspValid;
        rsp.single = rspSingle;
        rsp.line   = lineReg;
    end

    // host has no back-pressure, so a strobe while busy would be lost
    reqWhileBusy: assert property (@(posedge clk50MHz) disable iff (!rstN)
        req.valid |-> !busy)
        else $error("host request while busy");

    beatOverrun: assert property (@(posedge clk50MHz) disable iff (!rstN)
        wordValid |-> waitRead && beatCnt < beatsReq)
        else $error("more beats than requested");

endmodule

`default_nettype wire

// ==== cramController.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cram_cfg.svh"

module cramController (
    input  logic                clk50MHz,
    input  logic                rstN,
    input  cramPkg::cramCmd     cmd,
    input  logic [`CRAM_DW-1:0] mdataIn,
    output cramPkg::cramPins    pins,
    output logic                wordValid,
    output logic [`CRAM_DW-1:0] wordData,
    output logic                done,
    output logic [2:0]          latencyNow
);
    import cramPkg::*;

    // byte enables held asserted, strobes inactive
    localparam cramPins IdlePins = '{
        maddr:    '0,
        mdataOut: '0,
        mdataOe:  1'b0,
        moeN:     1'b1,
        mweN:     1'b1,
        madvN:    1'b1,
        mceN:     1'b1,
        mcre:     1'b0,
        mclkEn:   1'b0,
        mubN:     1'b0,
        mlbN:     1'b0
    };

    cramState   state;
    cramCmdOp   op;
    logic [2:0] waitCnt;
    logic [2:0] beatCnt;
    logic [2:0] latShadow;
    logic [2:0] cfgLat;     // clamped latency waiting for the CRE cycle
    logic [2:0] latClamped;
    cramCfgWord cfgIn;
    cramCfgWord cfgOut;

    always_comb begin
        cfgIn.raw = cmd.wdata;
        // overflow into the reserved bits saturates high
        if (|cfgIn.fields.reserved || cfgIn.fields.latency > 3'(`CRAM_LAT_MAX)) begin
            latClamped = 3'(`CRAM_LAT_MAX);
        end else if (cfgIn.fields.latency < 3'(`CRAM_LAT_MIN)) begin
            latClamped = 3'(`CRAM_LAT_MIN);
        end else begin
            latClamped = cfgIn.fields.latency;
        end
        cfgOut.fields.reserved  = '0;
        cfgOut.fields.latency   = latClamped;
        cfgOut.fields.burstWrap = cfgIn.fields.burstWrap;
    end

    always_ff @(posedge clk50MHz or negedge rstN) begin
        if (!rstN) begin
            state     <= stIdle;
            op        <= opRead;
            waitCnt   <= '0;
            beatCnt   <= '0;
            cfgLat    <= 3'(`CRAM_LAT_DEFAULT);
            latShadow <= 3'(`CRAM_LAT_DEFAULT);
            wordValid <= 1'b0;
            wordData  <= '0;
            done      <= 1'b0;
            pins      <= IdlePins;
        end else begin
            wordValid <= 1'b0;
            done      <= 1'b0;
            case (state)
                stIdle: begin
                    if (cmd.start) begin
                        op      <= cmd.op;
                        beatCnt <= cmd.beats - 3'd1;
                        waitCnt <= latShadow - 3'd1;
                        cfgLat  <= latClamped;
                        if (cmd.op == opCfgRead) begin
                            // no memory cycle, shadow returned as a single beat
                            wordValid <= 1'b1;
                            wordData  <= {{(`CRAM_DW-3){1'b0}}, latShadow};
                            done      <= 1'b1;
                        end else begin
                            state         <= stAddr;
                            pins.mceN     <= 1'b0;
                            pins.madvN    <= 1'b0;
                            pins.mclkEn   <= 1'b1;
                            pins.maddr    <= (cmd.op == opCfgWrite) ? cfgOut.raw : cmd.addr;
                            pins.mdataOut <= cmd.wdata;
                            pins.mweN     <= cmd.op != opWrite; // low from stAddr on writes
                        end
                    end
                end
                stAddr: begin
                    pins.madvN <= 1'b1;
                    if (op == opCfgWrite) begin
                        state     <= stCfg;
                        pins.mcre <= 1'b1;
                        pins.mweN <= 1'b0;
                    end else begin
                        state <= stWait;
                    end
                end
                stWait: begin
                    pins.moeN <= op != opRead; // low from the second wait cycle
                    if (waitCnt == 3'd0) begin
                        state        <= stData;
                        pins.mdataOe <= op == opWrite;
                    end else begin
                        waitCnt <= waitCnt - 3'd1;
                    end
                end
                stData: begin
                    if (op == opRead) begin
                        wordValid <= 1'b1;
                        wordData  <= mdataIn;
                    end
                    if (beatCnt == 3'd0) begin
                        state <= stIdle;
                        done  <= 1'b1;
                        pins  <= IdlePins;
                    end else begin
                        beatCnt <= beatCnt - 3'd1;
                    end
                end
                stCfg: begin
                    latShadow <= cfgLat;
                    state     <= stIdle;
                    done      <= 1'b1;
                    pins      <= IdlePins;
                end
                default: begin
                    state <= stIdle;
                    pins  <= IdlePins;
                end
            endcase
        end
    end

    assign latencyNow = latShadow;

    oeWeExclusive: assert property (@(posedge clk50MHz) disable iff (!rstN)
        !(!pins.mweN && !pins.moeN))
        else $error("mweN and moeN both low");

    advOnlyInAddr: assert property (@(posedge clk50MHz) disable iff (!rstN)
        !pins.madvN |-> state == stAddr)
        else $error("madvN low outside the address cycle");

endmodule

`default_nettype wire

// ==== cramTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cram_cfg.svh"

module cramTop (
    input  logic                clk50MHz,
    input  logic                rstN,
    input  busPkg::busReq       req,
    output busPkg::busRsp       rsp,
    output logic                busy,
    output cramPkg::cramPins    pins,
    input  logic [`CRAM_DW-1:0] mdataIn
);
    import cramPkg::*;

    cramCmd              cmd;
    logic                wordValid;
    logic [`CRAM_DW-1:0] wordData;
    logic                done;
    logic [2:0]          latencyNow;

    cramBusBridge i_cramBusBridge (
        .clk50MHz   (clk50MHz),
        .rstN       (rstN),
        .req        (req),
        .wordValid  (wordValid),
        .wordData   (wordData),
        .done       (done),
        .latencyNow (latencyNow),
        .cmd        (cmd),
        .rsp        (rsp),
        .busy       (busy)
    );

    cramController i_cramController (
        .clk50MHz   (clk50MHz),
        .rstN       (rstN),
        .cmd        (cmd),
        .mdataIn    (mdataIn),
        .pins       (pins),
        .wordValid  (wordValid),
        .wordData   (wordData),
        .done       (done),
        .latencyNow (latencyNow)
    );

endmodule

`default_nettype wire

// ==== tbCramModel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cram_cfg.svh"

module tbCramModel (
    input  logic                clk50MHz,
    input  cramPkg::cramPins    pins,
    output logic [`CRAM_DW-1:0] mdataIn
);
    import cramPkg::*;

    logic [`CRAM_DW-1:0] mem [0:(1<<`CRAM_AW)-1];
    logic [`CRAM_AW-1:0] baseAddr;
    logic [3:0]          cycCnt;   // edges since the address cycle
    logic [2:0]          lat;
    logic                isRead;

    initial begin
        lat      = 3'(`CRAM_LAT_DEFAULT);
        isRead   = 1'b0;
        cycCnt   = '0;
        baseAddr = '0;
        mdataIn  = '0;
        for (int i = 0; i < (1 << `CRAM_AW); i++) begin
            mem[i] = {i[7:0], i[15:8]} ^ 16'h5AA5; // scrambled byte swap of the address
        end
    end

    always @(posedge clk50MHz) begin
        cramCfgWord cfg;
        int         beat;
        beat = int'(cycCnt) - int'(lat) + 1;
        if (pins.mclkEn && !pins.mceN) begin
            if (!pins.madvN) begin
                baseAddr <= pins.maddr;
                isRead   <= pins.mweN; // CRE cycle looks like a read here
                cycCnt   <= '0;
            end else begin
                cycCnt <= cycCnt + 4'd1;
                if (pins.mcre && !pins.mweN) begin
                    cfg.raw = pins.maddr;
                    lat    <= cfg.fields.latency;
                    isRead <= 1'b0;
                end else if (pins.mdataOe && !pins.mweN) begin
                    // byte lanes written only where enabled
                    if (!pins.mubN) begin
                        mem[baseAddr][15:8] <= pins.mdataOut[15:8];
                    end
                    if (!pins.mlbN) begin
                        mem[baseAddr][7:0] <= pins.mdataOut[7:0];
                    end
                end
                // beat b goes out after the edge that ends wait cycle L+b
                if (isRead && !pins.moeN && beat >= 0 && beat < `CRAM_BURST_LEN) begin
                    mdataIn <= mem[baseAddr + 16'(beat)];
                end else begin
                    mdataIn <= 'x;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tbCram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cram_cfg.svh"

module tbCram;
    import busPkg::*;
    import cramPkg::*;

    localparam int LineW   = `CRAM_BURST_LEN * `CRAM_DW;
    localparam int MaxWait = 50; // cycles per wait loop

    logic                clk50MHz;
    logic                rstN;
    busReq               req;
    busRsp               rsp;
    logic                busy;
    cramPins             pins;
    logic [`CRAM_DW-1:0] mdataIn;

    logic [`CRAM_DW-1:0] shadow [0:(1<<`CRAM_AW)-1];
    logic [LineW-1:0]    expLineQ [$];
    int                  expWordsQ [$]; // words compared per response
    logic [15:0]         lfsr;
    int                  expLat;
    string               testName;

    cramTop i_cramTop (
        .clk50MHz (clk50MHz),
        .rstN     (rstN),
        .req      (req),
        .rsp      (rsp),
        .busy     (busy),
        .pins     (pins),
        .mdataIn  (mdataIn)
    );

    tbCramModel i_tbCramModel (
        .clk50MHz (clk50MHz),
        .pins     (pins),
        .mdataIn  (mdataIn)
    );

    always #10 clk50MHz = ~clk50MHz;

    function automatic logic [15:0] fillWord(input logic [15:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'h5AA5;
    endfunction

    // galois lfsr stepped once per bit taken
    function logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function logic [15:0] randAddr();
        logic [15:0] a;
        a = randBits(16);
        if (a == `CRAM_CTRL_ADDR) begin
            a = a ^ 16'h0100;
        end
        return a;
    endfunction

    function automatic int clampLat(input int lat);
        if (lat > `CRAM_LAT_MAX) begin
            return `CRAM_LAT_MAX;
        end else if (lat < `CRAM_LAT_MIN) begin
            return `CRAM_LAT_MIN;
        end
        return lat;
    endfunction

    function automatic logic [LineW-1:0] expectRead(input logic [15:0] addr, input int words);
        logic [LineW-1:0] line;
        line = '0;
        for (int k = 0; k < words; k++) begin
            line[k*`CRAM_DW +: `CRAM_DW] = shadow[16'(addr + k)];
        end
        return line;
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportMismatch(input string what, input logic [15:0] expVal,
                                  input logic [15:0] actVal);
        abortRun($sformatf("error %s %s expected %h actual %h", testName, what, expVal, actVal));
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk50MHz);
            n++;
            if (n > MaxWait) begin
                abortRun($sformatf("timeout in %s, busy never dropped", testName));
            end
        end
    endtask

    task automatic waitRsp();
        int n;
        n = 0;
        while (expWordsQ.size() != 0) begin
            @(posedge clk50MHz);
            n++;
            if (n > MaxWait) begin
                abortRun($sformatf("timeout in %s, no response arrived", testName));
            end
        end
    endtask

    task automatic issue(input accessKind kind, input logic [15:0] addr,
                         input logic [15:0] wdata, input int words,
                         input logic [LineW-1:0] expLine);
        waitIdle();
        expLineQ.push_back(expLine);
        expWordsQ.push_back(words);
        @(posedge clk50MHz);
        #2;
        req.valid = 1'b1;
        req.kind  = kind;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk50MHz);
        #2;
        req.valid = 1'b0;
        assert (busy) else abortRun("busy did not rise after an accepted request");
        waitRsp();
    endtask

    task automatic writeWord(input logic [15:0] addr, input logic [15:0] data);
        shadow[addr] = data;
        issue(accWrite, addr, data, 0, '0);
    endtask

    task automatic readWord(input logic [15:0] addr);
        issue(accRead, addr, '0, 1, expectRead(addr, 1));
    endtask

    task automatic readBurst(input logic [15:0] addr);
        issue(accBurstRead, addr, '0, `CRAM_BURST_LEN, expectRead(addr, `CRAM_BURST_LEN));
    endtask

    // latency field sits above the wrap bit so large values spill into reserved
    task automatic writeCtrl(input int lat);
        expLat = clampLat(lat);
        issue(accWrite, `CRAM_CTRL_ADDR, 16'(lat << 1), 0, '0);
    endtask

    task automatic readCtrl();
        issue(accRead, `CRAM_CTRL_ADDR, '0, 1, LineW'(expLat));
    endtask

    always @(negedge clk50MHz) begin
        logic [LineW-1:0] expLine;
        int               words;
        if (rstN && rsp.valid) begin
            assert (expWordsQ.size() != 0)
                else abortRun("response arrived with no request pending");
            assert (busy)
                else abortRun("busy is low during the response cycle");
            expLine = expLineQ.pop_front();
            words   = expWordsQ.pop_front();
            assert (rsp.single == (words != `CRAM_BURST_LEN))
                else reportMismatch("single", 16'(words != `CRAM_BURST_LEN), 16'(rsp.single));
            for (int k = 0; k < words; k++) begin
                assert (rsp.line[k*`CRAM_DW +: `CRAM_DW] === expLine[k*`CRAM_DW +: `CRAM_DW])
                    else reportMismatch($sformatf("word %0d", k),
                        expLine[k*`CRAM_DW +: `CRAM_DW], rsp.line[k*`CRAM_DW +: `CRAM_DW]);
            end
        end
    end

    initial begin
        logic [15:0] addrs [$];
        logic [15:0] a;
        logic [15:0] base;
        int          lats [2];
        clk50MHz = 1'b0;
        rstN     = 1'b0;
        req      = '0;
        lfsr     = 16'd51622;
        expLat   = `CRAM_LAT_DEFAULT;
        lats     = '{5, 9};
        testName = "reset";
        for (int i = 0; i < (1 << `CRAM_AW); i++) begin
            shadow[i] = fillWord(16'(i));
        end
        repeat (10) @(posedge clk50MHz);
        #2;
        rstN = 1'b1;
        @(negedge clk50MHz);
        assert (!busy) else abortRun("busy is high after reset");
        assert (pins.moeN && pins.mweN && pins.madvN && pins.mceN
                && !pins.mcre && !pins.mclkEn && !pins.mdataOe)
            else abortRun("memory strobes are active after reset");
        readCtrl();

        testName = "single";
        for (int i = 0; i < 16; i++) begin
            a = randAddr();
            writeWord(a, randBits(16));
            addrs.push_back(a);
        end
        foreach (addrs[i]) begin
            readWord(addrs[i]);
        end

        testName = "burst";
        for (int i = 0; i < 8; i++) begin
            base = randBits(14) << 2;
            if (base == (`CRAM_CTRL_ADDR & 16'hFFFC)) begin
                base = 16'h0100; // keep writes off the control address
            end
            if (i % 2 == 0) begin
                for (int k = 0; k < `CRAM_BURST_LEN; k++) begin
                    writeWord(16'(base + k), randBits(16));
                end
            end
            readBurst(base);
            readBurst({addrs[i][15:2], 2'b00});
        end

        testName = "latency";
        foreach (lats[j]) begin
            writeCtrl(lats[j]);
            readCtrl();
            for (int i = 0; i < 4; i++) begin
                a = randAddr();
                writeWord(a, randBits(16));
                readWord(a);
            end
            readBurst({addrs[j][15:2], 2'b00});
        end

        testName = "interleave";
        for (int i = 0; i < 4; i++) begin
            a = randAddr();
            writeWord(a, randBits(16));
            readCtrl();
            readWord(a);
            readCtrl();
            readBurst({a[15:2], 2'b00});
        end
        foreach (addrs[i]) begin
            readWord(addrs[i]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
busPkg.sv
cramPkg.sv
cramBusBridge.sv
cramController.sv
cramTop.sv
tbCramModel.sv
tbCram.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tbCram
RTL_TOP   ?= cramTop
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(shell grep -v '^+' $(FILELIST)) cram_cfg.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
